/* include/keypoint_settings.svh */
`ifndef KEYPOINT_SETTINGS_SVH
`define KEYPOINT_SETTINGS_SVH

// image geometry, one word per pixel
`define KP_IMG_W 16
`define KP_IMG_H 16

// pixel width in bits
`define KP_PIX_W 8

// smallest abs(dog) reported as a keypoint
`define KP_DOG_THRESHOLD 24

`endif

/* run.sh */
#!/bin/sh
# build and run the keypoint testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_keypoint_core -o sim_keypoint
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_keypoint)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
    exit 0
else
    exit 1
fi

/* source/dog_detector.sv */
`timescale 1ns/1ns
`default_nettype none

`include "keypoint_settings.svh"

module dog_detector import keypoint_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire logic   hsum_valid,
    input  col_entry_t  entry,
    input  coord_t      entry_row,
    input  coord_t      entry_col,
    input  col_entry_t  up1,
    input  col_entry_t  up2,
    output logic        out_valid,
    output logic [15:0] out_data,
    output logic        frame_done
);

    logic [11:0]       v_sum;   // up to 4 * 1020
    pixel_t            blur;
    logic signed [8:0] dog;
    pixel_t            abs_dog;
    logic              is_kp;
    logic              is_last;

    // vertical 1-2-1 centred on the row above the entry
    always_comb begin
        v_sum   = 12'(up2.sum) + (12'(up1.sum) << 1) + 12'(entry.sum);
        blur    = pixel_t'(v_sum >> 4); // kernel weight 16
        dog     = $signed({1'b0, up1.center}) - $signed({1'b0, blur});
        abs_dog = dog[8] ? pixel_t'(-dog) : pixel_t'(dog);
        is_kp   = hsum_valid && (entry_row >= coord_t'(2)) &&
                  (abs_dog >= pixel_t'(`KP_DOG_THRESHOLD));
        is_last = hsum_valid && (entry_row == coord_t'(`KP_IMG_H - 1)) &&
                  (entry_col == coord_t'(`KP_IMG_W - 2));
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            out_valid  <= is_kp;
            frame_done <= is_last;
        end
    end

    // row, column, magnitude
    always_ff @(posedge clk) begin
        if (is_kp)
            out_data <= {entry_row - coord_t'(1), entry_col, abs_dog};
    end

    // reported rows stay in the interior
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (out_data[15:12] >= 4'd1) && (out_data[15:12] <= 4'd14))
        else $error("dog_detector: keypoint row %0d out of range", out_data[15:12]);

    // one pulse per frame, frames are 224 entries apart
    assert property (@(posedge clk) disable iff (!rst_n)
        frame_done |=> !frame_done)
        else $error("dog_detector: frame_done held for two cycles");

endmodule

`default_nettype wire

/* source/keypoint_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "keypoint_settings.svh"

module keypoint_core import keypoint_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire logic   in_valid,
    input  pixel_t      in_data,
    output logic        out_valid,
    output logic [15:0] out_data,
    output logic        frame_done
);

    logic       hsum_valid;
    col_entry_t entry;
    coord_t     entry_row;
    coord_t     entry_col;
    col_entry_t up1;
    col_entry_t up2;

    row_gaussian u_row_gaussian (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .hsum_valid (hsum_valid),
        .entry      (entry),
        .entry_row  (entry_row),
        .entry_col  (entry_col)
    );

    line_buffer #(
        .DEPTH (`KP_IMG_W - 2) // interior columns only
    ) u_line_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .shift (hsum_valid),
        .entry (entry),
        .up1   (up1),
        .up2   (up2)
    );

    dog_detector u_dog_detector (
        .clk        (clk),
        .rst_n      (rst_n),
        .hsum_valid (hsum_valid),
        .entry      (entry),
        .entry_row  (entry_row),
        .entry_col  (entry_col),
        .up1        (up1),
        .up2        (up2),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .frame_done (frame_done)
    );

endmodule

`default_nettype wire

/* source/keypoint_pkg.sv */
`default_nettype none

`include "keypoint_settings.svh"

package keypoint_pkg;

    // raw input pixel
    typedef logic [`KP_PIX_W-1:0] pixel_t;

    // horizontal 1-2-1 sum, max 4 * 255
    typedef logic [9:0] hsum_t;

    // row or column index inside the frame
    typedef logic [3:0] coord_t;

    // one column of a row after the horizontal pass
    typedef struct packed {
        hsum_t  sum;    // p(c-1) + 2p(c) + p(c+1)
        pixel_t center; // raw p(c)
    } col_entry_t;

endpackage

`default_nettype wire

/* source/line_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module line_buffer import keypoint_pkg::*; #(
    parameter int DEPTH = 14 // entries per row
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic shift,
    input  col_entry_t entry,
    output col_entry_t up1,
    output col_entry_t up2
);

    // chain[0] is the newest entry
    col_entry_t chain [2*DEPTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2*DEPTH; i++) begin
                chain[i] <= '0;
            end
        end else if (shift) begin
            chain[0] <= entry;
            for (int i = 1; i < 2*DEPTH; i++) begin
                chain[i] <= chain[i-1];
            end
        end
    end

    // same column, one and two rows back
    assign up1 = chain[DEPTH-1];
    assign up2 = chain[2*DEPTH-1];

    // an unknown strobe would corrupt the whole row history
    assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(shift))
        else $error("line_buffer: shift is unknown");

endmodule

`default_nettype wire

/* source/row_gaussian.sv */
`timescale 1ns/1ns
`default_nettype none

`include "keypoint_settings.svh"

module row_gaussian import keypoint_pkg::*; (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic in_valid,
    input  pixel_t    in_data,
    output logic      hsum_valid,
    output col_entry_t entry,
    output coord_t    entry_row,
    output coord_t    entry_col
);

    coord_t row_cnt; // position of the incoming pixel
    coord_t col_cnt;
    pixel_t pix_d1;  // p(r, col_cnt-1)
    pixel_t pix_d2;  // p(r, col_cnt-2)
    logic   last_col;
    logic   last_row;
    logic   sum_ok;

    assign last_col = (col_cnt == coord_t'(`KP_IMG_W - 1));
    assign last_row = (row_cnt == coord_t'(`KP_IMG_H - 1));
    assign sum_ok   = (col_cnt >= coord_t'(2)); // two left neighbours present

    // raster position, wraps at the end of each frame
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_cnt <= '0;
            col_cnt <= '0;
        end else if (in_valid) begin
            if (last_col) begin
                col_cnt <= '0;
                row_cnt <= last_row ? '0 : row_cnt + coord_t'(1);
            end else begin
                col_cnt <= col_cnt + coord_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            hsum_valid <= 1'b0;
        else
            hsum_valid <= in_valid && sum_ok;
    end

    // pixel history and the sum for the column one to the left
    always_ff @(posedge clk) begin
        if (in_valid) begin
            pix_d1 <= in_data;
            pix_d2 <= pix_d1;
            if (sum_ok) begin
                entry.sum    <= hsum_t'(pix_d2) + (hsum_t'(pix_d1) << 1) + hsum_t'(in_data);
                entry.center <= pix_d1;
                entry_row    <= row_cnt;
                entry_col    <= col_cnt - coord_t'(1);
            end
        end
    end

    // only interior columns leave this stage
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(hsum_valid) |-> (entry_col != coord_t'(0)) &&
                              (entry_col != coord_t'(`KP_IMG_W - 1)))
        else $error("row_gaussian: border column %0d emitted", entry_col);

endmodule

`default_nettype wire

/* src.f */
+incdir+include
source/keypoint_pkg.sv
source/row_gaussian.sv
source/line_buffer.sv
source/dog_detector.sv
source/keypoint_core.sv
verification/tb_keypoint_core.sv

/* verification/tb_keypoint_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "keypoint_settings.svh"

module tb_keypoint_core import keypoint_pkg::*; ();

    localparam int NPIX = `KP_IMG_W * `KP_IMG_H;
    localparam int DONE_LIMIT = 50; // cycles after the last pixel

    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_valid;
    pixel_t      in_data;
    logic        out_valid;
    logic [15:0] out_data;
    logic        frame_done;

    int          cyc = 0;           // rising edges so far
    int          strobe_cyc [NPIX]; // drive time of each pixel
    logic [15:0] exp_q [$];
    int          exp_pix_q [$];     // pixel whose strobe releases the keypoint
    logic [15:0] exp_word;
    int          pix_idx;
    int          done_count = 0;
    int          kp_seen = 0;
    int          mon_errors = 0;
    int          err_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          errs_before;
    int          kp_mark;
    int          done_mark;
    bit          check_en = 1'b0;
    logic        rst_prev = 1'b1;
    integer      seed;
    pixel_t      img_flat [NPIX];
    pixel_t      img_spot [NPIX];
    pixel_t      img_rand [NPIX];
    pixel_t      img_rand2 [NPIX];

    keypoint_core DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .frame_done (frame_done)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
        cyc <= cyc + 1;

    // compare outputs against the expected list
    always @(posedge clk) begin
        if (!rst_n && !rst_prev && (out_valid === 1'b1 || frame_done === 1'b1)) begin
            $display("output active at %0t ns while reset was held low", $time);
            mon_errors++;
        end
        if (check_en && out_valid === 1'b1) begin
            kp_seen++;
            if (exp_q.size() == 0) begin
                $display("unexpected keypoint %h at %0t ns, none was expected", out_data, $time);
                mon_errors++;
            end else begin
                exp_word = exp_q.pop_front();
                pix_idx  = exp_pix_q.pop_front();
                if (out_data !== exp_word) begin
                    $display("CHECK FAILED at %0t ns: keypoint %h, expected %h",
                             $time, out_data, exp_word);
                    mon_errors++;
                end
                if (cyc != strobe_cyc[8'(pix_idx)] + 2) begin
                    $display("CHECK FAILED at %0t ns: keypoint %h came %0d cycles late, expected 2",
                             $time, out_data, cyc - strobe_cyc[8'(pix_idx)]);
                    mon_errors++;
                end
            end
        end
        if (check_en && frame_done === 1'b1) begin
            done_count++;
            if (cyc != strobe_cyc[NPIX-1] + 2) begin
                $display("CHECK FAILED at %0t ns: frame_done %0d cycles after last pixel, expected 2",
                         $time, cyc - strobe_cyc[NPIX-1]);
                mon_errors++;
            end
        end
        rst_prev <= rst_n;
    end

    // 1-2-1 across columns c-1..c+1 of row r
    function automatic int row_sum(input pixel_t image [NPIX], input int r, input int c);
        int base;
        base = r * `KP_IMG_W + c;
        return int'(image[8'(base - 1)]) + 2 * int'(image[8'(base)]) +
               int'(image[8'(base + 1)]);
    endfunction

    // expected keypoints of one frame, raster order
    function automatic void build_expected(input pixel_t image [NPIX]);
        int v;
        int blur;
        int dog;
        for (int r = 1; r < `KP_IMG_H - 1; r++) begin
            for (int c = 1; c < `KP_IMG_W - 1; c++) begin
                v    = row_sum(image, r - 1, c) + 2 * row_sum(image, r, c) +
                       row_sum(image, r + 1, c);
                blur = v / 16;
                dog  = int'(image[8'(r * `KP_IMG_W + c)]) - blur;
                if (dog < 0)
                    dog = -dog;
                if (dog >= `KP_DOG_THRESHOLD) begin
                    exp_q.push_back({4'(r), 4'(c), 8'(dog)});
                    exp_pix_q.push_back((r + 1) * `KP_IMG_W + c + 1); // pixel (r+1, c+1)
                end
            end
        end
    endfunction

    task automatic send_frame(input pixel_t image [NPIX], input bit gaps, input int count);
        int gap;
        for (int k = 0; k < count; k++) begin
            if (gaps) begin
                gap = $unsigned($random(seed)) % 4;
                in_valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
            in_valid = 1'b1;
            in_data  = image[8'(k)];
            strobe_cyc[8'(k)] = cyc;
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        in_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_done(input int target);
        int n;
        n = 0;
        while (done_count < target && n < DONE_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (done_count < target) begin
            $display("timeout: frame_done did not arrive within %0d cycles, at %0t ns",
                     DONE_LIMIT, $time);
            $display("ERRORS FOUND");
            $finish;
        end
    endtask

    task automatic check_drained();
        if (exp_q.size() != 0) begin
            $display("CHECK FAILED at %0t ns: %0d expected keypoints never arrived",
                     $time, exp_q.size());
            err_count++;
            exp_q.delete();
            exp_pix_q.delete();
        end
    endtask

    task automatic run_frame(input pixel_t image [NPIX], input bit gaps);
        int target;
        target = done_count + 1;
        build_expected(image);
        send_frame(image, gaps, NPIX);
        wait_done(target);
        idle(4);
        check_drained();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_count + mon_errors > errs_before) begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end else begin
            $display("test %0d %s: passed", tests_run, name);
        end
        errs_before = err_count + mon_errors;
    endtask

    initial begin
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_data     = '0;
        seed        = 73;
        errs_before = 0;
        for (int k = 0; k < NPIX; k++) begin
            img_flat[8'(k)]  = pixel_t'(100);
            img_spot[8'(k)]  = '0;
            img_rand[8'(k)]  = pixel_t'($random(seed));
            img_rand2[8'(k)] = pixel_t'($random(seed));
        end
        img_spot[8'(7 * `KP_IMG_W + 7)] = '1;

        repeat (5) @(negedge clk);
        rst_n    = 1'b1;
        check_en = 1'b1;
        idle(2);

        kp_mark   = kp_seen;
        done_mark = done_count;
        run_frame(img_flat, 1'b0);
        if (kp_seen != kp_mark || done_count != done_mark + 1) begin
            $display("CHECK FAILED at %0t ns: flat image gave %0d keypoints, %0d frame_done",
                     $time, kp_seen - kp_mark, done_count - done_mark);
            err_count++;
        end
        end_test("flat image");

        kp_mark = kp_seen;
        run_frame(img_spot, 1'b0);
        if (kp_seen == kp_mark) begin
            $display("no keypoint was reported around the bright pixel");
            err_count++;
        end
        end_test("single bright pixel");

        run_frame(img_rand, 1'b0);
        end_test("random image, no gaps");

        run_frame(img_rand, 1'b1); // same reference list as without gaps
        end_test("random image, random gaps");

        done_mark = done_count;
        build_expected(img_rand2);
        build_expected(img_rand);
        send_frame(img_rand2, 1'b0, NPIX);
        send_frame(img_rand, 1'b0, NPIX); // straight after, counters must wrap
        wait_done(done_mark + 2);
        idle(4);
        check_drained();
        if (done_count != done_mark + 2) begin
            $display("CHECK FAILED at %0t ns: %0d frame_done pulses for two frames",
                     $time, done_count - done_mark);
            err_count++;
        end
        end_test("two frames back to back");

        check_en = 1'b0;
        send_frame(img_rand2, 1'b0, 150);
        rst_n = 1'b0; // abort in mid-frame
        idle(5);
        rst_n    = 1'b1;
        check_en = 1'b1;
        idle(2);
        run_frame(img_rand, 1'b0);
        end_test("reset in mid-frame");

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, err_count + mon_errors);
        if (err_count + mon_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
